// ==== all.f ====
common/zports_pkg.sv
common/port_map_pkg.sv
source/io_decode.sv
source/req_fifo.sv
port_regs/port_regs.sv
port_regs/port_readback.sv
source/zports_top.sv
test/zports_props.sv
test/tb_zports.sv

// ==== common/port_map_pkg.sv ====
/*
 * port map for the Spectrum clone I/O block.
 * port numbers, #nnAF register indices, reset values and masks
 */
package port_map_pkg;

	// low address byte of the handled ports
	localparam logic [7:0] PORT_FE = 8'hFE;
	localparam logic [7:0] PORT_XT = 8'hAF;
	localparam logic [7:0] PORT_FD = 8'hFD;  // 7FFD with a15 low
	localparam logic [7:0] PORT_F7 = 8'hF7;  // EFF7 with a8 high, a12 low

	// extension register indices on #nnAF
	localparam logic [7:0] XT_RAMPAGE = 8'h10;  // #10..#13
	localparam logic [7:0] XT_FMADDR  = 8'h15;
	localparam logic [7:0] XT_SYSCONF = 8'h20;
	localparam logic [7:0] XT_MEMCONF = 8'h21;
	localparam logic [7:0] XT_IM2VECT = 8'h25;

	// register values after reset
	localparam logic [7:0] SYSCONF_RST = 8'h01;  // turbo 7 MHz
	localparam logic [7:0] MEMCONF_RST = 8'h04;  // no map
	localparam logic [7:0] IM2VECT_RST = 8'hFF;
	localparam logic [4:0] FMADDR_RST  = 5'h00;
	localparam logic [7:0] P7FFD_RST   = 8'h00;
	localparam logic [7:0] PEFF7_RST   = 8'h00;

	// rampage 3..0
	localparam logic [3:0][7:0] RAMPAGE_RST = {8'h00, 8'h02, 8'h05, 8'h00};

	// memconf[7:6] value that locks 7FFD paging to 128K
	localparam logic [1:0] MEMCONF_LOCK128 = 2'b01;

	// 7FFD bit that blocks further 7FFD writes
	localparam int P7FFD_BLOCK_BIT = 5;

	// bits of EFF7 left visible while 1M paging is blocked
	localparam logic [7:0] PEFF7_BLOCK_MASK = 8'b1011_0001;

	// floating bus value
	localparam logic [7:0] IDLE_READ = 8'hFF;

endpackage

// ==== common/zports_pkg.sv ====
/*
 * zports shared types for the port block pipeline.
 * CPU requests, classified queue entries, responses and the port address union
 */
package zports_pkg;

	// #nnAF view, high byte selects the extension register
	typedef struct packed {
		logic [7:0] idx;
		logic [7:0] port;
	} port_xt_t;

	// single address line view for the 7FFD / EFF7 decode
	typedef struct packed {
		logic       a15;
		logic       a14;
		logic       a13;
		logic       a12;
		logic [2:0] a11_9;
		logic       a8;
		logic [7:0] port;
	} port_bits_t;

	typedef union packed {
		port_xt_t   xt;
		port_bits_t bits;
	} port_addr_u;

	typedef enum logic [2:0] {
		KIND_FE,
		KIND_XT,
		KIND_P7FFD,
		KIND_PEFF7,
		KIND_OTHER
	} port_kind_e;

	typedef struct packed {
		port_addr_u addr;
		logic       rnw;   // 1 = IN, 0 = OUT
		logic [7:0] wdata;
	} cpu_req_t;

	typedef struct packed {
		port_kind_e kind;
		port_addr_u addr;
		logic       rnw;
		logic [7:0] data;  // write data, or input snapshot on #FE reads
	} port_req_t;

	typedef struct packed {
		logic       was_read;
		logic [7:0] rdata;
	} port_rsp_t;

endpackage

// ==== port_regs/port_readback.sv ====
/*
 * port_readback holds one response for the CPU side
 * and keeps it stable while rsp_ready is low
 */
`timescale 1ns/1ps

module port_readback
	import zports_pkg::*, port_map_pkg::*;
(
	input  logic      zclk,
	input  logic      rst_n,

	input  port_rsp_t exec_rsp,
	input  logic      exec_valid,
	output logic      exec_ready,

	output port_rsp_t rsp,
	output logic      rsp_valid,
	input  logic      rsp_ready
);

	port_rsp_t next_rsp;
	logic      load;

	// empty, or the held response leaves this cycle
	assign exec_ready = !rsp_valid || rsp_ready;
	assign load       = exec_valid && exec_ready;

	// OUT cycles see the idle bus
	always_comb
	begin
		next_rsp.was_read = exec_rsp.was_read;
		if (exec_rsp.was_read)
			next_rsp.rdata = exec_rsp.rdata;
		else
			next_rsp.rdata = IDLE_READ;
	end

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			rsp_valid <= 1'b0;
		else if (exec_ready)
			rsp_valid <= exec_valid;
	end

	always_ff @(posedge zclk)
	begin
		if (load)
			rsp <= next_rsp;  // held until taken
	end

endmodule

// ==== port_regs/port_regs.sv ====
/*
 * port_regs executes queued port writes to #nnAF, #7FFD, #EFF7, #FE
 * and forms the read data of each popped request
 */
`timescale 1ns/1ps

module port_regs
	import zports_pkg::*, port_map_pkg::*;
(
	input  logic       zclk,
	input  logic       rst_n,

	input  port_req_t  q_req,
	input  logic       q_valid,
	output logic       q_ready,

	output port_rsp_t  exec_rsp,
	output logic       exec_valid,
	input  logic       exec_ready,

	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [7:0]  im2vect,
	output logic [4:0]  fmaddr,
	output logic [31:0] xt_page,
	output logic [7:0]  peff7,
	output logic        p7ffd_1m_on,
	output logic        p7ffd_ram0_0,
	output logic        romrw_en,
	output logic        border_wr
);

	logic [3:0][7:0] rampage;
	logic [7:0]      p7ffd;
	logic [7:0]      peff7_reg;
	logic [7:0]      idx;
	logic [7:0]      rdata;
	logic            pop;
	logic            wr;
	logic            lock128;
	logic            block7ffd;

	// one response per pop, presented in the pop cycle
	assign q_ready    = exec_ready;
	assign exec_valid = q_valid;
	assign pop        = q_valid && q_ready;
	assign wr         = pop && !q_req.rnw;

	assign idx       = q_req.addr.xt.idx;
	assign lock128   = (memconf[7:6] == MEMCONF_LOCK128);
	assign block7ffd = p7ffd[P7FFD_BLOCK_BIT];

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			rampage   <= RAMPAGE_RST;
			fmaddr    <= FMADDR_RST;
			sysconf   <= SYSCONF_RST;
			memconf   <= MEMCONF_RST;
			im2vect   <= IM2VECT_RST;
			p7ffd     <= P7FFD_RST;
			peff7_reg <= PEFF7_RST;
			border_wr <= 1'b0;
		end
		else
		begin
			border_wr <= wr && (q_req.kind == KIND_FE);
			if (wr)
			begin
				case (q_req.kind)
					KIND_XT:
					begin
						if (idx[7:2] == XT_RAMPAGE[7:2])
							rampage[idx[1:0]] <= q_req.data;
						if (idx == XT_FMADDR)
							fmaddr <= q_req.data[4:0];
						if (idx == XT_SYSCONF)
							sysconf <= q_req.data;
						if (idx == XT_MEMCONF)
							memconf <= q_req.data;
						if (idx == XT_IM2VECT)
							im2vect <= q_req.data;
					end
					KIND_P7FFD:
					begin
						if (!block7ffd)  // locked until reset
						begin
							p7ffd      <= q_req.data;
							memconf[0] <= q_req.data[4];  // rom select
							rampage[3] <= {3'b000, lock128 ? 2'b00 : q_req.data[7:6],
								q_req.data[2:0]};
						end
					end
					KIND_PEFF7:
						peff7_reg <= q_req.data;
					default: ;
				endcase
			end
		end
	end

	// IN data
	always_comb
	begin
		rdata = IDLE_READ;
		case (q_req.kind)
			KIND_FE:
				rdata = q_req.data;  // snapshot from decode
			KIND_XT:
			begin
				if (idx == XT_RAMPAGE + 8'd2 || idx == XT_RAMPAGE + 8'd3)
					rdata = rampage[idx[1:0]];
			end
			default: ;
		endcase
	end

	assign exec_rsp.was_read = q_req.rnw;
	assign exec_rsp.rdata    = rdata;

	assign xt_page = rampage;  // {rampage3, rampage2, rampage1, rampage0}

	// bit 2 blocks 1M paging and hides its config bits
	assign peff7        = peff7_reg[2] ? (peff7_reg & PEFF7_BLOCK_MASK) : peff7_reg;
	assign p7ffd_1m_on  = ~peff7_reg[2];
	assign p7ffd_ram0_0 = peff7_reg[3];
	assign romrw_en     = memconf[1];

endmodule

// ==== source/io_decode.sv ====
/*
 * io_decode takes CPU port requests, classifies the port and
 * samples keys/tape for #FE reads into a single output register
 */
`timescale 1ns/1ps

module io_decode
	import zports_pkg::*, port_map_pkg::*;
(
	input  logic      zclk,
	input  logic      rst_n,

	input  cpu_req_t  cpu_req,
	input  logic      req_valid,
	output logic      req_ready,

	input  logic [4:0] keys_in,
	input  logic       tape_read,

	output port_req_t dec_req,
	output logic      dec_valid,
	input  logic      dec_ready
);

	port_kind_e kind;
	port_req_t  next_req;

	// port classes, a15 and a8/a12 come from the bit view
	always_comb
	begin
		if (cpu_req.addr.xt.port == PORT_FE)
			kind = KIND_FE;
		else if (cpu_req.addr.xt.port == PORT_XT)
			kind = KIND_XT;
		else if (cpu_req.addr.bits.port == PORT_FD && !cpu_req.addr.bits.a15)
			kind = KIND_P7FFD;
		else if (cpu_req.addr.bits.port == PORT_F7 && cpu_req.addr.bits.a8
				&& !cpu_req.addr.bits.a12)
			kind = KIND_PEFF7;
		else
			kind = KIND_OTHER;  // AY at #FFFD/#BFFD lands here too
	end

	always_comb
	begin
		next_req.kind = kind;
		next_req.addr = cpu_req.addr;
		next_req.rnw  = cpu_req.rnw;
		if (kind == KIND_FE && cpu_req.rnw)
			next_req.data = {1'b1, tape_read, 1'b0, keys_in};  // sampled as the IN is offered
		else
			next_req.data = cpu_req.wdata;
	end

	// register empty or draining this cycle
	assign req_ready = !dec_valid || dec_ready;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
			dec_valid <= 1'b0;
		else if (req_ready)
			dec_valid <= req_valid;
	end

	always_ff @(posedge zclk)
	begin
		if (req_valid && req_ready)
			dec_req <= next_req;
	end

endmodule

// ==== source/req_fifo.sv ====
/*
 * req_fifo is a circular queue of classified port requests
 * between the decoder and the register file
 */
`timescale 1ns/1ps

module req_fifo
	import zports_pkg::*;
#(
	parameter int FIFO_DEPTH = 4  // power of two
)
(
	input  logic      zclk,
	input  logic      rst_n,

	input  port_req_t in_req,
	input  logic      in_valid,
	output logic      in_ready,

	output port_req_t out_req,
	output logic      out_valid,
	input  logic      out_ready
);

	localparam int AW = $clog2(FIFO_DEPTH);
	localparam logic [AW:0] FULL_CNT = (AW+1)'(FIFO_DEPTH);

	port_req_t mem [FIFO_DEPTH];

	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0]   count;
	logic          push;
	logic          pop;

	assign in_ready  = (count != FULL_CNT);
	assign out_valid = (count != '0);  // no fall-through
	assign out_req   = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop  = out_valid && out_ready;

	always_ff @(posedge zclk)
	begin
		if (!rst_n)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;  // idle, or push and pop together
			endcase
		end
	end

	always_ff @(posedge zclk)
	begin
		if (push)
			mem[wr_ptr] <= in_req;
	end

endmodule

// ==== source/zports_top.sv ====
/*
 * zports top, the I/O port pipeline of decoder, request queue,
 * register file and response stage
 */
`timescale 1ns/1ps

module zports_top
	import zports_pkg::*;
#(
	parameter int FIFO_DEPTH = 4
)
(
	input  logic        zclk,
	input  logic        rst_n,

	input  cpu_req_t    cpu_req,
	input  logic        req_valid,
	output logic        req_ready,

	output port_rsp_t   rsp,
	output logic        rsp_valid,
	input  logic        rsp_ready,

	input  logic [4:0]  keys_in,
	input  logic        tape_read,

	output logic [7:0]  sysconf,
	output logic [7:0]  memconf,
	output logic [7:0]  im2vect,
	output logic [4:0]  fmaddr,
	output logic [31:0] xt_page,
	output logic [7:0]  peff7,
	output logic        p7ffd_1m_on,
	output logic        p7ffd_ram0_0,
	output logic        romrw_en,
	output logic        border_wr
);

	port_req_t dec_req;
	logic      dec_valid;
	logic      dec_ready;
	port_req_t q_req;
	logic      q_valid;
	logic      q_ready;
	port_rsp_t exec_rsp;
	logic      exec_valid;
	logic      exec_ready;

	io_decode u_decode (
		.zclk(zclk), .rst_n(rst_n),
		.cpu_req(cpu_req), .req_valid(req_valid), .req_ready(req_ready),
		.keys_in(keys_in), .tape_read(tape_read),
		.dec_req(dec_req), .dec_valid(dec_valid), .dec_ready(dec_ready)
	);

	req_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
		.zclk(zclk), .rst_n(rst_n),
		.in_req(dec_req), .in_valid(dec_valid), .in_ready(dec_ready),
		.out_req(q_req), .out_valid(q_valid), .out_ready(q_ready)
	);

	port_regs u_regs (
		.zclk(zclk), .rst_n(rst_n),
		.q_req(q_req), .q_valid(q_valid), .q_ready(q_ready),
		.exec_rsp(exec_rsp), .exec_valid(exec_valid), .exec_ready(exec_ready),
		.sysconf(sysconf), .memconf(memconf), .im2vect(im2vect), .fmaddr(fmaddr),
		.xt_page(xt_page), .peff7(peff7), .p7ffd_1m_on(p7ffd_1m_on),
		.p7ffd_ram0_0(p7ffd_ram0_0), .romrw_en(romrw_en), .border_wr(border_wr)
	);

	port_readback u_readback (
		.zclk(zclk), .rst_n(rst_n),
		.exec_rsp(exec_rsp), .exec_valid(exec_valid), .exec_ready(exec_ready),
		.rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready)
	);

endmodule

// ==== test/tb_zports.sv ====
/*
 * testbench for the zports I/O pipeline.
 * random port traffic with response stalls, checked against a register model
 */
`timescale 1ns/1ps

module tb_zports
	import zports_pkg::*;
();

	localparam int NUM_REQ = 400;
	localparam int WATCHDOG_CYCLES = NUM_REQ * 20 + 200;
	localparam logic [7:0] XT_IDX [8] = '{8'h10, 8'h11, 8'h12, 8'h13,
		8'h15, 8'h20, 8'h21, 8'h25};

	typedef struct packed {
		cpu_req_t   req;
		logic [7:0] snap;  // expected #FE input byte
	} pend_t;

	logic        zclk = 1'b0;
	logic        rst_n;
	cpu_req_t    cpu_req;
	logic        req_valid, req_ready;
	port_rsp_t   rsp;
	logic        rsp_valid, rsp_ready;
	logic [4:0]  keys_in;
	logic        tape_read;
	logic [7:0]  sysconf, memconf, im2vect, peff7;
	logic [4:0]  fmaddr;
	logic [31:0] xt_page;
	logic        p7ffd_1m_on, p7ffd_ram0_0, romrw_en, border_wr;

	// model copies of the port registers
	logic [7:0] m_rampage [4] = '{8'h00, 8'h05, 8'h02, 8'h00};
	logic [4:0] m_fmaddr = 5'h00;
	logic [7:0] m_sysconf = 8'h01;
	logic [7:0] m_memconf = 8'h04;
	logic [7:0] m_im2vect = 8'hFF;
	logic [7:0] m_p7ffd = 8'h00;
	logic [7:0] m_peff7 = 8'h00;

	pend_t pending [$];
	int    issued = 0;
	int    resp_cnt = 0;
	int    border_cnt = 0;
	int    border_exp = 0;
	logic  accepted_now = 1'b0;

	zports_top #(.FIFO_DEPTH(4)) dut (
		.zclk(zclk), .rst_n(rst_n),
		.cpu_req(cpu_req), .req_valid(req_valid), .req_ready(req_ready),
		.rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
		.keys_in(keys_in), .tape_read(tape_read),
		.sysconf(sysconf), .memconf(memconf), .im2vect(im2vect), .fmaddr(fmaddr),
		.xt_page(xt_page), .peff7(peff7), .p7ffd_1m_on(p7ffd_1m_on),
		.p7ffd_ram0_0(p7ffd_ram0_0), .romrw_en(romrw_en), .border_wr(border_wr)
	);

	bind zports_top zports_props props (
		.zclk(zclk), .rst_n(rst_n),
		.cpu_req(cpu_req), .req_valid(req_valid), .req_ready(req_ready),
		.rsp(rsp), .rsp_valid(rsp_valid), .rsp_ready(rsp_ready),
		.border_wr(border_wr)
	);

	always #20 zclk = ~zclk;

	function automatic port_kind_e classify(logic [15:0] a);
		if (a[7:0] == 8'hFE)
			return KIND_FE;
		if (a[7:0] == 8'hAF)
			return KIND_XT;
		if (a[7:0] == 8'hFD && !a[15])
			return KIND_P7FFD;
		if (a[7:0] == 8'hF7 && a[8] && !a[12])
			return KIND_PEFF7;
		return KIND_OTHER;
	endfunction

	function automatic cpu_req_t make_req(int n);
		cpu_req_t   r;
		logic [7:0] hi;
		int         sel;
		hi = $urandom;
		sel = $urandom % 10;
		r.rnw = $urandom;
		r.wdata = $urandom;
		if (n < 2)
		begin
			r.addr = {8'h12 + 8'(n), 8'hAF};  // rampage 2/3 right after reset
			r.rnw = 1'b1;
		end
		else if (sel < 2)
			r.addr = {hi, 8'hFE};
		else if (sel < 5)
		begin
			if ($urandom % 5 != 0)
				hi = XT_IDX[$urandom % 8];
			r.addr = {hi, 8'hAF};
		end
		else if (sel < 7)
		begin
			hi[7] = ($urandom % 4 == 0);  // a15 mostly low
			if (n < NUM_REQ * 3 / 4)
				r.wdata[5] = 1'b0;  // keep 7FFD unlocked for a while
			r.addr = {hi, 8'hFD};
		end
		else if (sel < 9)
		begin
			hi[0] = ($urandom % 4 != 0);  // a8
			hi[4] = ($urandom % 4 == 0);  // a12
			r.addr = {hi, 8'hF7};
		end
		else
			r.addr = $urandom;
		return r;
	endfunction

	function automatic port_rsp_t predict_rsp(pend_t p);
		port_rsp_t  e;
		logic [7:0] idx;
		idx = p.req.addr[15:8];
		e.was_read = p.req.rnw;
		e.rdata = 8'hFF;
		if (p.req.rnw && classify(p.req.addr) == KIND_FE)
			e.rdata = p.snap;
		else if (p.req.rnw && classify(p.req.addr) == KIND_XT
				&& (idx == 8'h12 || idx == 8'h13))
			e.rdata = m_rampage[idx - 8'h10];
		return e;
	endfunction

	task automatic apply_write(input cpu_req_t r);
		logic [7:0] idx;
		logic [7:0] d;
		idx = r.addr[15:8];
		d = r.wdata;
		case (classify(r.addr))
			KIND_XT:
			begin
				if (idx >= 8'h10 && idx <= 8'h13)
					m_rampage[idx - 8'h10] = d;
				else if (idx == 8'h15)
					m_fmaddr = d[4:0];
				else if (idx == 8'h20)
					m_sysconf = d;
				else if (idx == 8'h21)
					m_memconf = d;
				else if (idx == 8'h25)
					m_im2vect = d;
			end
			KIND_P7FFD:
			begin
				if (!m_p7ffd[5])
				begin
					m_rampage[3] = {3'b000, (m_memconf[7:6] == 2'b01) ? 2'b00 : d[7:6], d[2:0]};
					m_memconf[0] = d[4];
					m_p7ffd = d;
				end
			end
			KIND_PEFF7:
				m_peff7 = d;
			KIND_FE:
				border_exp++;
			default: ;
		endcase
	endtask

	task automatic compare_rsp(input logic [15:0] addr, input port_rsp_t got,
			input port_rsp_t exp);
		if (got !== exp)
		begin
			$display("ERR rsp (port %h) got %h exp %h", addr, got, exp);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic expect_byte(input string name, input logic [7:0] got,
			input logic [7:0] exp);
		if (got !== exp)
		begin
			$display("ERR %s got %h exp %h", name, got, exp);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic verify_page(input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp)
		begin
			$display("ERR xt_page got %h exp %h", got, exp);
			$display("Result: FAILED");
			$fatal(1);
		end
	endtask

	task automatic check_outputs();
		logic [7:0] peff7_exp;
		peff7_exp = m_peff7[2] ? (m_peff7 & 8'b1011_0001) : m_peff7;
		expect_byte("sysconf", sysconf, m_sysconf);
		expect_byte("memconf", memconf, m_memconf);
		expect_byte("im2vect", im2vect, m_im2vect);
		expect_byte("fmaddr", {3'b000, fmaddr}, {3'b000, m_fmaddr});
		verify_page(xt_page, {m_rampage[3], m_rampage[2], m_rampage[1], m_rampage[0]});
		expect_byte("peff7", peff7, peff7_exp);
		expect_byte("p7ffd_1m_on", {7'd0, p7ffd_1m_on}, {7'd0, ~m_peff7[2]});
		expect_byte("p7ffd_ram0_0", {7'd0, p7ffd_ram0_0}, {7'd0, m_peff7[3]});
		expect_byte("romrw_en", {7'd0, romrw_en}, {7'd0, m_memconf[1]});
	endtask

	// values at the falling edge are the ones the next rising edge sees
	always @(negedge zclk)
	begin
		pend_t     p;
		port_rsp_t exp;
		if (rst_n)
		begin
			if (rsp_valid && rsp_ready)
			begin
				if (pending.size() == 0)
				begin
					$display("response arrived with no request outstanding");
					$display("Result: FAILED");
					$fatal(1);
				end
				p = pending.pop_front();
				exp = predict_rsp(p);
				compare_rsp(p.req.addr, rsp, exp);
				resp_cnt++;
				if (!p.req.rnw)
				begin
					apply_write(p.req);
					check_outputs();  // later requests not popped yet
				end
			end
			accepted_now = req_valid && req_ready;
			if (accepted_now)
			begin
				p.req = cpu_req;
				p.snap = {1'b1, tape_read, 1'b0, keys_in};
				pending.push_back(p);
			end
			if (border_wr)
				border_cnt++;
		end
	end

	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge zclk);
		$display("timeout: not all responses arrived within %0d cycles", WATCHDOG_CYCLES);
		$display("Result: FAILED");
		$fatal(1);
	end

	initial
	begin
		void'($urandom(32'h6ba0_eaff));
		rst_n = 1'b0;
		cpu_req = '0;
		req_valid = 1'b0;
		rsp_ready = 1'b0;
		keys_in = 5'h00;
		tape_read = 1'b0;
		repeat (3) @(posedge zclk);
		#2 rst_n = 1'b1;
		check_outputs();
		expect_byte("req_ready", {7'd0, req_ready}, 8'h01);
		expect_byte("rsp_valid", {7'd0, rsp_valid}, 8'h00);
		expect_byte("border_wr", {7'd0, border_wr}, 8'h00);
		while (resp_cnt < NUM_REQ)
		begin
			@(posedge zclk);
			#2;
			rsp_ready = ($urandom % 4) < (((issued / 64) % 2 == 1) ? 1 : 3);  // stall windows
			if (!req_valid || accepted_now)
			begin
				if (issued < NUM_REQ && ($urandom % 4) != 0)
				begin
					cpu_req = make_req(issued);
					keys_in = $urandom;
					tape_read = $urandom;
					req_valid = 1'b1;
					issued++;
				end
				else
					req_valid = 1'b0;
			end
		end
		rsp_ready = 1'b1;
		repeat (8) @(posedge zclk);
		if (pending.size() == 0 && border_cnt == border_exp && !rsp_valid)
		begin
			$display("Result: PASSED");
			$finish;
		end
		else
		begin
			$display("end of run mismatch: %0d pending, border pulses %0d, expected %0d",
				pending.size(), border_cnt, border_exp);
			$display("Result: FAILED");
			$fatal(1);
		end
	end

endmodule

// ==== test/zports_props.sv ====
/*
 * handshake and reset properties bound onto zports_top
 */
`timescale 1ns/1ps

module zports_props
	import zports_pkg::*;
(
	input logic      zclk,
	input logic      rst_n,
	input cpu_req_t  cpu_req,
	input logic      req_valid,
	input logic      req_ready,
	input port_rsp_t rsp,
	input logic      rsp_valid,
	input logic      rsp_ready,
	input logic      border_wr
);

	// offered request stays put until taken
	req_hold: assert property (@(posedge zclk) disable iff (!rst_n)
		req_valid && !req_ready |=> req_valid && $stable(cpu_req))
		else $error("request dropped or changed before transfer");

	// stalled response keeps its payload
	rsp_hold: assert property (@(posedge zclk) disable iff (!rst_n)
		rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp))
		else $error("response dropped or changed before transfer");

	reset_quiet: assert property (@(posedge zclk)
		!rst_n |=> !rsp_valid && !border_wr)
		else $error("rsp_valid or border_wr active in reset");

	reset_ready: assert property (@(posedge zclk)
		!rst_n |=> req_ready)
		else $error("req_ready low after reset");

endmodule
